// ==== vlog.f ====
+incdir+include
hw/cpuPkg.sv
hw/alu.sv
hw/sequencer.sv
hw/programCounter.sv
hw/dataPath.sv
hw/cpuTop.sv
testbench/cpuTb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - include_dirs:
      - include
    files:
      - hw/cpuPkg.sv
      - hw/alu.sv
      - hw/sequencer.sv
      - hw/programCounter.sv
      - hw/dataPath.sv
      - hw/cpuTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/cpuTb.sv

// ==== testbench/cpuTb.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuTb;
  import cpuPkg::*;

  logic       CLK;
  logic       RESET;
  wordType    romAddress;
  wordType    romData;
  busReqType  busReq;
  wordType    busDataIn;
  logic [1:0] interruptRaise;
  logic [1:0] interruptAck;

  // Memory models and the reference copy of the RAM
  wordType rom [0:255];
  wordType ram [0:255];
  wordType modelRam [0:255];

  // Predicted events, consumed in order by the monitor
  busReqType  expWrites[$];
  logic [1:0] expAcks[$];

  integer  seed;
  int      errorCount;
  int      errorsBefore;
  int      okTests;
  int      badTests;
  wordType genPc;
  // Instruction-level model state
  wordType mPc;
  wordType mA;
  wordType mB;

  cpuTop dut (
    .CLK            (CLK),
    .RESET          (RESET),
    .romAddress     (romAddress),
    .romData        (romData),
    .busReq         (busReq),
    .busDataIn      (busDataIn),
    .interruptRaise (interruptRaise),
    .interruptAck   (interruptAck)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Synchronous ROM and RAM
  always @(posedge CLK) begin
    romData   <= rom[romAddress];
    busDataIn <= ram[busReq.addr];
    if (busReq.writeEnable === 1'b1) ram[busReq.addr] <= busReq.data;
  end

  // Bus and acknowledge monitor
  always @(posedge CLK) begin
    if (!RESET && busReq.writeEnable === 1'b1) begin
      if (expWrites.size() == 0) begin
        $display("Fail at %0t: unexpected bus write to %h data %h", $time,
                 busReq.addr, busReq.data);
        errorCount++;
      end else begin
        checkWrite(busReq, expWrites.pop_front());
      end
    end
    if (!RESET && interruptAck !== 2'b00) begin
      if (expAcks.size() == 0) begin
        $display("Fail at %0t: unexpected interrupt acknowledge %b", $time, interruptAck);
        errorCount++;
      end else begin
        checkAck(interruptAck, expAcks.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////
  // Compare tasks
  task checkWrite(input busReqType got, input busReqType exp);
    if (got.addr !== exp.addr || got.data !== exp.data) begin
      $display("Fail at %0t: bus write addr %h data %h, expected addr %h data %h", $time,
               got.addr, got.data, exp.addr, exp.data);
      errorCount++;
    end
  endtask

  task checkAck(input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: interrupt acknowledge %b, expected %b", $time, got, exp);
      errorCount++;
    end
  endtask

  task checkIdleBus(input busReqType got);
    if (got.writeEnable !== 1'b0 || got.addr !== `idleBusAddr) begin
      $display("Fail at %0t: bus request we %b addr %h, expected idle", $time,
               got.writeEnable, got.addr);
      errorCount++;
    end
  endtask

  //////////////////////////////////////////////////
  // Program generator
  function wordType randomWord();
    return wordType'($random(seed));
  endfunction

  // ALU code in the high nibble, opcode in the low one
  function wordType encode(input logic [3:0] hi, input opcodeType op);
    return {hi, op};
  endfunction

  task emit(input wordType value);
    rom[genPc] = value;
    genPc      = genPc + 8'd1;
  endtask

  // Fresh ROM of goto-idle bytes and random RAM
  task prepareMemories;
    int i;
    errorsBefore = errorCount;
    expWrites.delete();
    expAcks.delete();
    for (i = 0; i < 256; i++) begin
      rom[i]      = encode(i[7:4] ^ i[3:0], opGotoIdle);
      ram[i]      = randomWord();
      modelRam[i] = ram[i];
    end
    genPc = 8'h00;
  endtask

  //////////////////////////////////////////////////
  // Reference model
  function wordType modelAlu(input logic [3:0] op, input wordType a, input wordType b);
    case (op)
      4'h0: return a + b;
      4'h1: return a - b;
      4'h2: return a & b;
      4'h3: return a | b;
      4'h4: return a ^ b;
      4'h5: return {a[6:0], 1'b0};
      4'h6: return {1'b0, a[7:1]};
      4'h7: return a + 8'd1;
      4'h8: return (a == b) ? 8'd1 : 8'd0;
      4'h9: return (a < b) ? 8'd1 : 8'd0;
      4'hA: return (a > b) ? 8'd1 : 8'd0;
      default: return 8'd0;
    endcase
  endfunction

  // Interpret from mPc up to the next goto idle
  task runModel;
    wordType instr;
    wordType operand;
    int      steps;
    logic    done;
    steps = 0;
    done  = 1'b0;
    while (!done && steps < 500) begin
      instr   = rom[mPc];
      operand = rom[wordType'(mPc + 8'd1)];
      steps++;
      case (opcodeType'(instr[3:0]))
        opReadA, opReadB: begin
          if (instr[0]) mB = modelRam[operand];
          else mA = modelRam[operand];
          mPc = mPc + 8'd2;
        end
        opWriteA, opWriteB: begin
          modelRam[operand] = instr[0] ? mB : mA;
          expWrites.push_back('{addr: operand, data: modelRam[operand], writeEnable: 1'b1});
          mPc = mPc + 8'd2;
        end
        opAluA: mA = modelAlu(instr[7:4], mA, mB);
        opAluB: mB = modelAlu(instr[7:4], mA, mB);
        opBranchEq: mPc = (mA == mB) ? operand : mPc + 8'd2;
        opBranchLt: mPc = (mA < mB) ? operand : mPc + 8'd2;
        opBranchGt: mPc = (mA > mB) ? operand : mPc + 8'd2;
        opGoto: mPc = operand;
        opGotoIdle: done = 1'b1;
        opDerefA: mA = modelRam[mA];
        opDerefB: mB = modelRam[mB];
        default: ;
      endcase
      // One-byte instructions step here
      if (instr[3:0] inside {4'h4, 4'h5, 4'hA, 4'hB, 4'hC, 4'hD, 4'hE, 4'hF}) begin
        mPc = mPc + 8'd1;
      end
    end
    if (!done) begin
      $display("The model did not reach goto idle within 500 instructions");
      errorCount++;
    end
  endtask

  //////////////////////////////////////////////////
  // Reset, waits and bookkeeping
  task checkResetState;
    checkIdleBus(busReq);
    checkAck(interruptAck, 2'b00);
  endtask

  task applyReset;
    int i;
    @(posedge CLK);
    RESET <= 1'b1;
    for (i = 0; i < 4; i++) begin
      @(posedge CLK);
      if (i > 0) checkResetState();
    end
    RESET <= 1'b0;
    // First cycle out of reset still shows the reset values
    @(posedge CLK);
    checkResetState();
  endtask

  task waitDrain(input int limit);
    int n;
    n = 0;
    while ((expWrites.size() != 0 || expAcks.size() != 0) && n < limit) begin
      @(posedge CLK);
      n++;
    end
    if (expWrites.size() != 0 || expAcks.size() != 0) begin
      $display("Timeout after %0d cycles: %0d bus writes and %0d acknowledges never came",
               n, expWrites.size(), expAcks.size());
      errorCount++;
      expWrites.delete();
      expAcks.delete();
    end
    // Quiet window catches stray writes and lets the FSM reach idle
    n = 0;
    while (n < 24) begin
      @(posedge CLK);
      n++;
    end
  endtask

  task runMain;
    mPc = `resetPc;
    mA  = 8'h00;
    mB  = 8'h00;
    runModel();
    applyReset();
    waitDrain(2000);
  endtask

  task finishTest(input string name);
    if (errorCount == errorsBefore) begin
      okTests++;
      $display("[%s] ok", name);
    end else begin
      badTests++;
      $display("[%s] %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  task loadAluStoreTest;
    int   k;
    logic toB;
    prepareMemories();
    for (k = 0; k < 4; k++) begin
      toB = randomWord() > 8'h7F;
      emit(encode(4'h0, opReadA));
      emit(randomWord());
      emit(encode(4'h0, opReadB));
      emit(randomWord());
      emit(encode(randomWord() % 8'd16, toB ? opAluB : opAluA));
      emit(encode(4'h0, toB ? opWriteB : opWriteA));
      emit(randomWord());
    end
    emit(encode(4'h0, opGotoIdle));
    runMain();
    finishTest("load alu store");
  endtask

  // Marker D0+2k on the fall-through path, D1+2k on the taken one
  task branchTest;
    int        k;
    wordType   x;
    wordType   bAddr;
    opcodeType br;
    aluOpType  cmp;
    prepareMemories();
    for (k = 0; k < 6; k++) begin
      x = randomWord();
      case (k % 3)
        0: begin
          br  = opBranchEq;
          cmp = aluEq;
        end
        1: begin
          br  = opBranchLt;
          cmp = aluLt;
        end
        default: begin
          br  = opBranchGt;
          cmp = aluGt;
        end
      endcase
      emit(encode(4'h0, opReadA));
      emit(x);
      emit(encode(4'h0, opReadB));
      // Same address half the time so equal operands show up
      emit(randomWord() > 8'h7F ? x : randomWord());
      bAddr = genPc;
      emit(encode(cmp, br));
      emit(bAddr + 8'd6);
      emit(encode(4'h0, opWriteA));
      emit(8'hD0 + wordType'(2 * k));
      emit(encode(4'h0, opGoto));
      emit(bAddr + 8'd8);
      emit(encode(4'h0, opWriteA));
      emit(8'hD1 + wordType'(2 * k));
    end
    emit(encode(4'h0, opGotoIdle));
    runMain();
    finishTest("branches");
  endtask

  task gotoTest;
    int k;
    prepareMemories();
    for (k = 0; k < 2; k++) begin
      emit(encode(4'h0, k ? opReadB : opReadA));
      emit(randomWord());
      emit(encode(4'h0, opGoto));
      emit(genPc + 8'd3);
      // Skipped write
      emit(encode(4'h0, opWriteA));
      emit(8'h30);
      emit(encode(4'h0, k ? opWriteB : opWriteA));
      emit(8'h31 + wordType'(k));
    end
    emit(encode(4'h0, opGotoIdle));
    runMain();
    finishTest("goto");
  endtask

  task derefTest;
    prepareMemories();
    emit(encode(4'h0, opReadA));
    emit(randomWord());
    emit(encode(4'h0, opDerefA));
    emit(encode(4'h0, opWriteA));
    emit(randomWord());
    emit(encode(4'h0, opReadB));
    emit(randomWord());
    emit(encode(4'h0, opDerefB));
    emit(encode(4'h0, opWriteB));
    emit(randomWord());
    emit(encode(4'h0, opGotoIdle));
    runMain();
    finishTest("dereference");
  endtask

  // Thread reads a word, increments it and stores it at its own marker
  task buildThread(input wordType start, input wordType marker);
    genPc = start;
    emit(encode(4'h0, opReadA));
    emit(randomWord());
    emit(encode(aluInc, opAluA));
    emit(encode(4'h0, opWriteA));
    emit(marker);
    emit(encode(4'h0, opGotoIdle));
  endtask

  task raiseInterrupt(input logic [1:0] lines);
    int n;
    // Line 0 has priority
    expAcks.push_back(lines[0] ? 2'b01 : 2'b10);
    mPc = rom[lines[0] ? `vectorA : `vectorB];
    runModel();
    @(posedge CLK);
    interruptRaise <= lines;
    n = 0;
    while (expAcks.size() != 0 && n < 50) begin
      @(posedge CLK);
      n++;
    end
    if (expAcks.size() != 0) begin
      $display("Timeout after %0d cycles: no interrupt acknowledge for lines %b", n, lines);
      errorCount++;
      expAcks.delete();
    end
    interruptRaise <= 2'b00;
    waitDrain(1000);
  endtask

  task interruptTest;
    int      round;
    wordType start0;
    wordType start1;
    prepareMemories();
    emit(encode(4'h0, opReadA));
    emit(randomWord());
    emit(encode(4'h0, opWriteA));
    emit(randomWord());
    emit(encode(4'h0, opGotoIdle));
    start0 = 8'h80 + (randomWord() & 8'h0F);
    start1 = 8'hB0 + (randomWord() & 8'h0F);
    rom[`vectorA] = start0;
    rom[`vectorB] = start1;
    buildThread(start0, 8'hE0);
    buildThread(start1, 8'hE1);
    runMain();
    raiseInterrupt(2'b11);
    for (round = 0; round < 4; round++) begin
      raiseInterrupt(2'(randomWord() % 8'd3 + 8'd1));
    end
    finishTest("idle and interrupts");
  endtask

  // Reset values are checked inside applyReset
  task resetTest;
    prepareMemories();
    emit(encode(4'h0, opGotoIdle));
    runMain();
    finishTest("reset values");
  endtask

  initial begin
    seed           = 32'h0c4b_9e6a;
    errorCount     = 0;
    okTests        = 0;
    badTests       = 0;
    RESET          = 1'b1;
    romData        = '0;
    busDataIn      = '0;
    interruptRaise = 2'b00;
    loadAluStoreTest();
    branchTest();
    gotoTest();
    derefTest();
    interruptTest();
    resetTest();
    $display("%0d tests ok, %0d tests with errors, %0d errors in total",
             okTests, badTests, errorCount);
    if (errorCount == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== hw/cpuTop.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module cpuTop (
  input  logic                  CLK,
  input  logic                  RESET,
  // Program ROM, synchronous read
  output logic [`dataWidth-1:0] romAddress,
  input  logic [`dataWidth-1:0] romData,
  // Data RAM and peripherals
  output cpuPkg::busReqType     busReq,
  input  logic [`dataWidth-1:0] busDataIn,
  // Interrupt lines, line 0 first
  input  logic [1:0]            interruptRaise,
  output logic [1:0]            interruptAck
);
  import cpuPkg::*;

  // Decoded control, one word per cycle
  ctrlType ctrl;
  // Branch condition back to the FSM
  logic    aluNonZero;

  sequencer seqInst (
    .CLK            (CLK),
    .RESET          (RESET),
    .romData        (romData),
    .aluNonZero     (aluNonZero),
    .interruptRaise (interruptRaise),
    .ctrl           (ctrl),
    .interruptAck   (interruptAck)
  );

  programCounter pcInst (
    .CLK        (CLK),
    .RESET      (RESET),
    .ctrl       (ctrl),
    .romData    (romData),
    .romAddress (romAddress)
  );

  dataPath dpInst (
    .CLK        (CLK),
    .RESET      (RESET),
    .ctrl       (ctrl),
    .romData    (romData),
    .busDataIn  (busDataIn),
    .busReq     (busReq),
    .aluNonZero (aluNonZero)
  );

endmodule

// ==== hw/dataPath.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module dataPath (
  input  logic              CLK,
  input  logic              RESET,
  input  cpuPkg::ctrlType   ctrl,
  input  cpuPkg::wordType   romData,
  input  cpuPkg::wordType   busDataIn,
  output cpuPkg::busReqType busReq,
  output logic              aluNonZero
);
  import cpuPkg::*;

  wordType  regA;
  wordType  regB;
  // 0 picks A, 1 picks B
  logic     regSelect;
  wordType  aluResult;
  aluOpType aluOp;
  wordType  nextAddr;
  wordType  busAddrQ;
  wordType  busDataQ;
  logic     busWriteQ;

  // ALU op is the high half of the opcode byte
  assign aluOp = aluOpType'(romData[`dataWidth-1:`dataWidth/2]);

  alu aluInst (
    .a      (regA),
    .b      (regB),
    .op     (aluOp),
    .result (aluResult)
  );

  assign aluNonZero = |aluResult;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      regA      <= '0;
      regB      <= '0;
      regSelect <= 1'b0;
    end else begin
      if (ctrl.setSelect) regSelect <= ctrl.selectValue;
      case (ctrl.regLoad)
        regFromBus: begin
          if (regSelect) regB <= busDataIn;
          else regA <= busDataIn;
        end
        regAluToA: regA <= aluResult;
        regAluToB: regB <= aluResult;
        default: ;
      endcase
    end
  end

  // Address falls back to idle between accesses
  always_comb begin
    case (ctrl.busAddrSrc)
      busFromRom: nextAddr = romData;
      busFromA:   nextAddr = regA;
      busFromB:   nextAddr = regB;
      default:    nextAddr = `idleBusAddr;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      busAddrQ  <= `idleBusAddr;
      busWriteQ <= 1'b0;
    end else begin
      busAddrQ  <= nextAddr;
      busWriteQ <= ctrl.busWrite;
    end
  end

  // Write data held until the next write
  always_ff @(posedge CLK) begin
    if (ctrl.busWrite) busDataQ <= regSelect ? regB : regA;
  end

  assign busReq = '{addr: busAddrQ, data: busDataQ, writeEnable: busWriteQ};

endmodule

// ==== hw/programCounter.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module programCounter (
  input  logic            CLK,
  input  logic            RESET,
  input  cpuPkg::ctrlType ctrl,
  input  cpuPkg::wordType romData,
  output cpuPkg::wordType romAddress
);
  import cpuPkg::*;

  wordType pc;
  // Points one past the opcode to fetch the operand byte
  logic    offset;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      pc     <= `resetPc;
      offset <= 1'b0;
    end else begin
      offset <= ctrl.operandOffset;
      case (ctrl.pcCmd)
        pcInc1:     pc <= pc + wordType'(1);
        pcInc2:     pc <= pc + wordType'(2);
        pcLoadRom:  pc <= romData;
        pcLoadVecA: pc <= `vectorA;
        pcLoadVecB: pc <= `vectorB;
        default:    pc <= pc;
      endcase
    end
  end

  // ROM samples this at the next edge
  assign romAddress = pc + wordType'(offset);

  // Operand fetch never overlaps a jump
  offsetNoJump: assert property (@(posedge CLK) disable iff (RESET)
    ctrl.operandOffset |-> !(ctrl.pcCmd inside {pcLoadRom, pcLoadVecA, pcLoadVecB}));

endmodule

// ==== hw/sequencer.sv ====
`timescale 1ns/100ps
`include "cpu_consts.svh"

module sequencer (
  input  logic            CLK,
  input  logic            RESET,
  input  cpuPkg::wordType romData,
  input  logic            aluNonZero,
  input  logic [1:0]      interruptRaise,
  output cpuPkg::ctrlType ctrl,
  output logic [1:0]      interruptAck
);
  import cpuPkg::*;

  typedef enum logic [4:0] {
    stIdle, stThreadStart0, stThreadStart1, stThreadStart2, stChooseOp,
    stReadToA, stReadToB, stReadMem0, stReadMem1, stReadMem2,
    stWriteFromA, stWriteFromB, stWriteMem0,
    stAluToA, stAluToB, stAluWait, stNoOp,
    stBranchEqual, stBranchLess, stBranchGreater, stBranchTaken, stBranchWait,
    stGotoAddr, stGotoAddr0, stGotoAddr1, stGotoIdle, stGotoIdle0,
    stDerefA, stDerefB, stDeref0, stDeref1
  } stateType;

  stateType  state;
  stateType  nextState;
  logic [1:0] nextAck;
  opcodeType opcode;

  // Opcode sits in the low half of the instruction byte
  assign opcode = opcodeType'(romData[`dataWidth/2-1:0]);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state        <= stChooseOp;
      interruptAck <= 2'b00;
    end else begin
      state        <= nextState;
      interruptAck <= nextAck;
    end
  end

  always_comb begin
    nextState          = state;
    nextAck            = 2'b00;
    ctrl.pcCmd         = pcHold;
    ctrl.operandOffset = 1'b0;
    ctrl.regLoad       = regNone;
    ctrl.setSelect     = 1'b0;
    ctrl.selectValue   = 1'b0;
    ctrl.busAddrSrc    = busIdle;
    ctrl.busWrite      = 1'b0;
    case (state)
      //////////////////////////////////////////////////
      // Idle and thread start
      stIdle: begin
        // Line 0 wins when both are raised
        if (interruptRaise[0]) begin
          ctrl.pcCmd = pcLoadVecA;
          nextAck    = 2'b01;
          nextState  = stThreadStart0;
        end else if (interruptRaise[1]) begin
          ctrl.pcCmd = pcLoadVecB;
          nextAck    = 2'b10;
          nextState  = stThreadStart0;
        end
      end
      // ROM fetches the thread pointer
      stThreadStart0: nextState = stThreadStart1;
      stThreadStart1: begin
        ctrl.pcCmd = pcLoadRom;
        nextState  = stThreadStart2;
      end
      //////////////////////////////////////////////////
      // Opcode select, operand byte requested here
      stChooseOp: begin
        ctrl.operandOffset = 1'b1;
        case (opcode)
          opReadA:    nextState = stReadToA;
          opReadB:    nextState = stReadToB;
          opWriteA:   nextState = stWriteFromA;
          opWriteB:   nextState = stWriteFromB;
          opAluA:     nextState = stAluToA;
          opAluB:     nextState = stAluToB;
          opBranchEq: nextState = stBranchEqual;
          opBranchLt: nextState = stBranchLess;
          opBranchGt: nextState = stBranchGreater;
          opGoto:     nextState = stGotoAddr;
          opGotoIdle: nextState = stGotoIdle;
          opDerefA:   nextState = stDerefA;
          opDerefB:   nextState = stDerefB;
          // B, C and F just step over one byte
          default:    nextState = stNoOp;
        endcase
      end
      //////////////////////////////////////////////////
      // Memory read, operand byte is the address
      stReadToA, stReadToB: begin
        ctrl.setSelect   = 1'b1;
        ctrl.selectValue = (state == stReadToB);
        nextState        = stReadMem0;
      end
      stReadMem0: begin
        ctrl.busAddrSrc = busFromRom;
        nextState       = stReadMem1;
      end
      // Step two ahead so the next opcode is ready in time
      stReadMem1: begin
        ctrl.pcCmd = pcInc2;
        nextState  = stReadMem2;
      end
      stReadMem2: begin
        ctrl.regLoad = regFromBus;
        nextState    = stChooseOp;
      end
      // Memory write
      stWriteFromA, stWriteFromB: begin
        ctrl.setSelect   = 1'b1;
        ctrl.selectValue = (state == stWriteFromB);
        ctrl.pcCmd       = pcInc2;
        nextState        = stWriteMem0;
      end
      stWriteMem0: begin
        ctrl.busAddrSrc = busFromRom;
        ctrl.busWrite   = 1'b1;
        nextState       = stChooseOp;
      end
      //////////////////////////////////////////////////
      // ALU result captured while the opcode byte is still on romData
      stAluToA, stAluToB: begin
        ctrl.regLoad = (state == stAluToA) ? regAluToA : regAluToB;
        ctrl.pcCmd   = pcInc1;
        nextState    = stAluWait;
      end
      stNoOp: begin
        ctrl.pcCmd = pcInc1;
        nextState  = stAluWait;
      end
      // Compare op comes from the instruction's high nibble
      stBranchEqual, stBranchLess, stBranchGreater: begin
        if (aluNonZero) begin
          nextState = stBranchTaken;
        end else begin
          ctrl.pcCmd = pcInc2;
          nextState  = stBranchWait;
        end
      end
      stBranchTaken: begin
        ctrl.pcCmd = pcLoadRom;
        nextState  = stBranchWait;
      end
      // Goto, wait for the operand byte then jump
      stGotoAddr: nextState = stGotoAddr0;
      stGotoAddr0: begin
        ctrl.pcCmd = pcLoadRom;
        nextState  = stGotoAddr1;
      end
      // ROM settles on the new address
      stThreadStart2, stAluWait, stBranchWait, stGotoAddr1: nextState = stChooseOp;
      stGotoIdle: begin
        ctrl.pcCmd = pcInc1;
        nextState  = stGotoIdle0;
      end
      stGotoIdle0: nextState = stIdle;
      //////////////////////////////////////////////////
      // Dereference, register drives the bus address
      stDerefA, stDerefB: begin
        ctrl.setSelect   = 1'b1;
        ctrl.selectValue = (state == stDerefB);
        ctrl.busAddrSrc  = (state == stDerefB) ? busFromB : busFromA;
        nextState        = stDeref0;
      end
      stDeref0: begin
        ctrl.pcCmd = pcInc1;
        nextState  = stDeref1;
      end
      stDeref1: begin
        ctrl.regLoad = regFromBus;
        nextState    = stChooseOp;
      end
      default: nextState = stChooseOp;
    endcase
  end

  // Acknowledge is one-hot and lasts a single cycle
  ackPulse: assert property (@(posedge CLK) disable iff (RESET)
    (interruptAck != 2'b00) |-> $onehot(interruptAck) ##1 (interruptAck == 2'b00));

  // Writes only at the end of a write instruction
  writeOnlyFromWrite: assert property (@(posedge CLK) disable iff (RESET)
    ctrl.busWrite |-> (state == stWriteMem0) &&
                      ($past(state) inside {stWriteFromA, stWriteFromB}));

endmodule

// ==== hw/alu.sv ====
`timescale 1ns/100ps

module alu (
  input  cpuPkg::wordType  a,
  input  cpuPkg::wordType  b,
  input  cpuPkg::aluOpType op,
  output cpuPkg::wordType  result
);
  import cpuPkg::*;

  always_comb begin
    case (op)
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr:  result = a | b;
      aluXor: result = a ^ b;
      // Shifts and increment act on A only
      aluShl: result = a << 1;
      aluShr: result = a >> 1;
      aluInc: result = a + wordType'(1);
      // Compares give 1 or 0 for the branch test
      aluEq:  result = wordType'(a == b);
      aluLt:  result = wordType'(a < b);
      aluGt:  result = wordType'(a > b);
      default: result = '0;
    endcase
  end

endmodule

// ==== hw/cpuPkg.sv ====
`include "cpu_consts.svh"

package cpuPkg;

  // Data, address and instruction word
  typedef logic [`dataWidth-1:0] wordType;

  // Low nibble of the instruction byte
  // B and C are no-operations since call and return are gone
  typedef enum logic [3:0] {
    opReadA     = 4'h0,
    opReadB     = 4'h1,
    opWriteA    = 4'h2,
    opWriteB    = 4'h3,
    opAluA      = 4'h4,
    opAluB      = 4'h5,
    opBranchEq  = 4'h6,
    opBranchLt  = 4'h7,
    opBranchGt  = 4'h8,
    opGoto      = 4'h9,
    opGotoIdle  = 4'hA,
    opNopB      = 4'hB,
    opNopC      = 4'hC,
    opDerefA    = 4'hD,
    opDerefB    = 4'hE
  } opcodeType;

  // High nibble of the instruction byte
  typedef enum logic [3:0] {
    aluAdd = 4'h0,
    aluSub = 4'h1,
    aluAnd = 4'h2,
    aluOr  = 4'h3,
    aluXor = 4'h4,
    aluShl = 4'h5,
    aluShr = 4'h6,
    aluInc = 4'h7,
    aluEq  = 4'h8,
    aluLt  = 4'h9,
    aluGt  = 4'hA
  } aluOpType;

  //////////////////////////////////////////////////
  // Control word from the sequencer

  typedef enum logic [2:0] {
    pcHold, pcInc1, pcInc2, pcLoadRom, pcLoadVecA, pcLoadVecB
  } pcCmdType;

  typedef enum logic [1:0] {
    regNone, regFromBus, regAluToA, regAluToB
  } regLoadType;

  typedef enum logic [1:0] {
    busIdle, busFromRom, busFromA, busFromB
  } busAddrSrcType;

  typedef struct packed {
    pcCmdType      pcCmd;
    logic          operandOffset;
    regLoadType    regLoad;
    logic          setSelect;
    logic          selectValue;
    busAddrSrcType busAddrSrc;
    logic          busWrite;
  } ctrlType;

  // One data bus access
  typedef struct packed {
    wordType addr;
    wordType data;
    logic    writeEnable;
  } busReqType;

endpackage

// ==== include/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Width of data words, bus addresses and instruction bytes
`define dataWidth 8

//////////////////////////////////////////////////
// Interrupt thread pointers in ROM

// Line 0 start address lives here
`define vectorA 8'hFF

// Line 1 start address lives here
`define vectorB 8'hFE

//////////////////////////////////////////////////
// Bus and program counter defaults

// Address left on the bus between accesses
`define idleBusAddr 8'hFF

// First instruction fetched after reset
`define resetPc 8'h00

`endif
